//--- filelist.f
hw/rtcMenuPkg.sv
hw/rtcBusIf.sv
hw/sweepSequencer.sv
hw/rtcBusMaster.sv
hw/rtcShadowRegs.sv
hw/cursorControl.sv
hw/alarmTimer.sv
hw/rtcMenu.sv
verification/rtcMenu_properties.sv
verification/rtcMenuTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rtcMenuTb
FILELIST = filelist.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/rtcMenuTb.sv
`timescale 1ns/1ps

module rtcMenuTb;

	localparam int WaitCycles = 5;
	localparam int AlarmCycles = 3;
	localparam int TransferMax = 12;            // Worst four-phase transfer incl. 4-cycle ack delay
	localparam int SweepMax = 11 * TransferMax + WaitCycles + 2;
	localparam int CycleLimit = 10 * SweepMax + 400;  // Up to ten sweeps waited on plus edit phases

	// Register window in sweep order and in cursor ring order
	localparam logic [6:0] SweepOrder [11] = '{7'h21, 7'h22, 7'h23, 7'h24, 7'h25, 7'h26,
		7'h27, 7'h41, 7'h42, 7'h43, 7'h44};

	localparam logic [4:0] PressLeft = 5'b00001;
	localparam logic [4:0] PressRight = 5'b00010;
	localparam logic [4:0] PressUp = 5'b00100;
	localparam logic [4:0] PressDown = 5'b01000;
	localparam logic [4:0] PressCenter = 5'b10000;

	logic CLK, RST, irq;
	logic btnUp, btnDown, btnLeft, btnRight, btnCenter;
	logic [7:0] busRdata, busWdata, cursorValue;
	logic busAck, busReq, busWe, writing, alarm, stopwatch;
	logic [6:0] busAddr, cursor;

	logic [7:0] mem [11];                       // RTC chip registers
	logic [7:0] expShadow [11];                 // Expected shadow contents
	logic [6:0] logAddr [$];                    // Accesses of the latest sweep
	logic logWe [$];
	logic logWriting [$];
	int sweepStarts = 0;
	int sweepEnds = 0;
	int errors = 0;
	int assertFails = 0;
	int cycles = 0;

	rtcMenu #(.WaitCycles(WaitCycles), .AlarmCycles(AlarmCycles)) rtcMenu_i (
		.CLK(CLK), .RST(RST), .irq(irq),
		.btnUp(btnUp), .btnDown(btnDown), .btnLeft(btnLeft), .btnRight(btnRight),
		.btnCenter(btnCenter), .busRdata(busRdata), .busAck(busAck),
		.busReq(busReq), .busWe(busWe), .busAddr(busAddr), .busWdata(busWdata),
		.cursor(cursor), .cursorValue(cursorValue), .writing(writing),
		.alarm(alarm), .stopwatch(stopwatch)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;                 // 20 ns period
	end

	// Run limit
	always @(posedge CLK)
	begin
		cycles = cycles + 1;
		if (cycles >= CycleLimit)
		begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////
	// Helpers
	////////////////////
	function automatic int slotOf(input logic [6:0] addr);
		for (int i = 0; i < 11; i++)
			if (SweepOrder[i] == addr)
				return i;
		return 0;
	endfunction

	function automatic logic [7:0] toBcd(input int n);
		return {4'(n / 10), 4'(n % 10)};
	endfunction

	function automatic int fromBcd(input logic [7:0] b);
		return 10 * int'(b[7:4]) + int'(b[3:0]);
	endfunction

	// Decimal step modulo 100
	function automatic logic [7:0] bcdStep(input logic [7:0] b, input int dir);
		return toBcd((fromBcd(b) + 100 + dir) % 100);
	endfunction

	task automatic reportMismatch(input string testName, input string what,
		input logic [7:0] expected, input logic [7:0] actual);
		errors++;
		$display("** Error [%s] %s: expected %h, actual %h", testName, what, expected, actual);
	endtask

	// One-cycle pulse with the result visible a cycle later
	task automatic pressButton(input logic [4:0] btn);
		@(posedge CLK);
		btnLeft <= btn[0];
		btnRight <= btn[1];
		btnUp <= btn[2];
		btnDown <= btn[3];
		btnCenter <= btn[4];
		@(posedge CLK);
		btnLeft <= 1'b0;
		btnRight <= 1'b0;
		btnUp <= 1'b0;
		btnDown <= 1'b0;
		btnCenter <= 1'b0;
		@(posedge CLK);
	endtask

	task automatic checkCursor(input string testName, input logic [6:0] expAddr);
		if (cursor !== expAddr)
			reportMismatch(testName, "cursor", 8'(expAddr), 8'(cursor));
		if (cursorValue !== expShadow[slotOf(expAddr)])
			reportMismatch(testName, "cursorValue", expShadow[slotOf(expAddr)], cursorValue);
	endtask

	// Waits for the next sweep to start and run to its end
	task automatic waitFullSweep();
		int target;
		@(negedge CLK);                         // Mid-cycle so a sweep seen at the last edge counts
		target = sweepStarts + 1;
		wait (sweepStarts >= target);
		wait (sweepEnds >= target);
		repeat (3) @(posedge CLK);              // Ready comes the cycle after ack low is seen
	endtask

	task automatic compareSweepLog(input string testName, input logic expWrite);
		if (logAddr.size() != 11)
			reportMismatch(testName, "transfer count", 8'd11, 8'(logAddr.size()));
		for (int i = 0; i < logAddr.size() && i < 11; i++)
		begin
			if (logAddr[i] !== SweepOrder[i])
				reportMismatch(testName, "transfer address", 8'(SweepOrder[i]), 8'(logAddr[i]));
			if (logWe[i] !== expWrite)
				reportMismatch(testName, "busWe", 8'(expWrite), 8'(logWe[i]));
			if (logWriting[i] !== expWrite)
				reportMismatch(testName, "writing", 8'(expWrite), 8'(logWriting[i]));
		end
	endtask

	////////////////////
	// RTC chip model
	////////////////////
	initial
	begin
		int delay;
		int idx;
		void'($urandom(76664));
		for (int i = 0; i < 11; i++)
			mem[i] = toBcd((int'(SweepOrder[i]) * 7) % 100);  // Pattern from full address
		mem[0] = 8'h59;                           // Edit targets
		mem[1] = 8'h99;
		busAck <= 1'b0;
		busRdata <= 8'h00;
		forever
		begin
			@(posedge CLK);
			if (busReq === 1'b1 && busAck === 1'b0)
			begin
				idx = slotOf(busAddr);
				if (busAddr == 7'h21)
				begin
					logAddr.delete();             // New sweep
					logWe.delete();
					logWriting.delete();
					sweepStarts++;
				end
				logAddr.push_back(busAddr);
				logWe.push_back(busWe);
				logWriting.push_back(writing);
				delay = $urandom_range(4, 1);
				repeat (delay - 1) @(posedge CLK);
				if (busWe)
					mem[idx] = busWdata;
				else
					busRdata <= mem[idx];
				busAck <= 1'b1;
				@(posedge CLK);
				while (busReq === 1'b1)
					@(posedge CLK);
				busAck <= 1'b0;                   // Four-phase release
				if (busAddr == 7'h44)
					sweepEnds++;
			end
		end
	end

	////////////////////
	// Tests
	////////////////////
	task automatic readSweep();
		waitFullSweep();
		compareSweepLog("readSweep", 1'b0);
		for (int i = 0; i < 11; i++)
			expShadow[i] = mem[i];
		if (cursorValue !== mem[0])
			reportMismatch("readSweep", "cursorValue at 0x21", mem[0], cursorValue);
	endtask

	task automatic cursorWraps();
		int slot;
		slot = 0;
		for (int i = 0; i < 11; i++)
		begin
			pressButton(PressLeft);
			slot = (slot + 1) % 11;               // 0x27 jumps to 0x41 and 0x44 wraps home
			checkCursor("cursorWraps", SweepOrder[slot]);
		end
		for (int i = 0; i < 5; i++)
		begin
			pressButton(PressRight);
			slot = (slot + 10) % 11;              // Home to 0x44 and then down to 0x41 and 0x27
			checkCursor("cursorWraps", SweepOrder[slot]);
		end
		pressButton(PressCenter);
		checkCursor("cursorWraps", 7'h21);
		waitFullSweep();                          // Center commits too
		compareSweepLog("cursorWraps", 1'b1);
	endtask

	task automatic bcdEdit();
		checkCursor("bcdEdit", 7'h21);
		pressButton(PressUp);
		expShadow[0] = bcdStep(expShadow[0], 1);  // 59 to 60
		checkCursor("bcdEdit", 7'h21);
		pressButton(PressLeft);
		checkCursor("bcdEdit", 7'h22);
		pressButton(PressUp);
		expShadow[1] = bcdStep(expShadow[1], 1);  // 99 to 00
		checkCursor("bcdEdit", 7'h22);
		pressButton(PressDown);
		expShadow[1] = bcdStep(expShadow[1], -1); // 00 to 99
		checkCursor("bcdEdit", 7'h22);
		pressButton(PressDown);
		expShadow[1] = bcdStep(expShadow[1], -1);
		checkCursor("bcdEdit", 7'h22);
		mem[0] = 8'h11;                           // Chip changes under pending edits
		mem[1] = 8'h33;
		mem[4] = 8'h44;
		waitFullSweep();
		compareSweepLog("bcdEdit", 1'b0);
		checkCursor("bcdEdit", 7'h22);
		pressButton(PressRight);
		checkCursor("bcdEdit", 7'h21);
	endtask

	task automatic commitWrite();
		pressButton(PressCenter);
		checkCursor("commit", 7'h21);
		waitFullSweep();
		compareSweepLog("commit", 1'b1);
		for (int i = 0; i < 11; i++)
			if (mem[i] !== expShadow[i])
				reportMismatch("commit", $sformatf("model byte at %h", SweepOrder[i]),
					expShadow[i], mem[i]);
		mem[0] = 8'h27;
		mem[9] = 8'h31;
		waitFullSweep();                          // Back to reading
		compareSweepLog("commit", 1'b0);
		for (int i = 0; i < 11; i++)
			expShadow[i] = mem[i];
		checkCursor("commit", 7'h21);
	endtask

	task automatic alarmPulse();
		logic expAlarm;
		logic expStop;
		@(posedge CLK);
		irq <= 1'b1;
		@(posedge CLK);
		irq <= 1'b0;
		for (int c = 1; c <= AlarmCycles + 1; c++)
		begin
			@(posedge CLK);
			irq <= (c == 1);                      // Second irq mid-alarm
			expAlarm = (c <= AlarmCycles);
			expStop = (c == AlarmCycles);
			if (alarm !== expAlarm)
				reportMismatch("alarm", $sformatf("alarm in cycle %0d", c), 8'(expAlarm),
					8'(alarm));
			if (stopwatch !== expStop)
				reportMismatch("alarm", $sformatf("stopwatch in cycle %0d", c), 8'(expStop),
					8'(stopwatch));
		end
	endtask

	initial
	begin
		RST <= 1'b1;
		irq <= 1'b0;
		btnUp <= 1'b0;
		btnDown <= 1'b0;
		btnLeft <= 1'b0;
		btnRight <= 1'b0;
		btnCenter <= 1'b0;
		repeat (4) @(posedge CLK);
		if (busReq !== 1'b0) reportMismatch("reset", "busReq", 8'd0, 8'(busReq));
		if (writing !== 1'b0) reportMismatch("reset", "writing", 8'd0, 8'(writing));
		if (alarm !== 1'b0) reportMismatch("reset", "alarm", 8'd0, 8'(alarm));
		if (stopwatch !== 1'b0) reportMismatch("reset", "stopwatch", 8'd0, 8'(stopwatch));
		if (cursor !== 7'h21) reportMismatch("reset", "cursor", 8'h21, 8'(cursor));
		if (cursorValue !== 8'h00) reportMismatch("reset", "cursorValue", 8'h00, cursorValue);
		RST <= 1'b0;
		readSweep();
		cursorWraps();
		bcdEdit();
		commitWrite();
		alarmPulse();
		assertFails = rtcMenu_i.props_i.failCount;
		$display("Summary: 5 tests run, %0d errors, %0d assertion failures, %0d cycles",
			errors, assertFails, cycles);
		if (errors == 0 && assertFails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verification/rtcMenu_properties.sv
`timescale 1ns/1ps

module rtcMenu_properties #(
	parameter int AlarmCycles = 3
) (
	input logic CLK,
	input logic RST,
	input logic busReq,
	input logic busAck,
	input logic alarm,
	input logic stopwatch
);

	int failCount = 0;                 // Failed assertions so far

	////////////////////
	// RTC pins
	////////////////////
	reqHeld: assert property (@(posedge CLK) disable iff (RST)
		busReq && !busAck |=> busReq)    // No withdraw before ack
		else
		begin
			failCount++;
			$error("busReq dropped before busAck");
		end

	////////////////////
	// Alarm pulse
	////////////////////

	// Stopwatch only in the last alarm cycle
	stopInAlarm: assert property (@(posedge CLK) disable iff (RST)
		stopwatch |-> alarm ##1 !alarm)
		else
		begin
			failCount++;
			$error("stopwatch outside the last alarm cycle");
		end

	// Alarm never ends without its stopwatch strobe
	stopAtEnd: assert property (@(posedge CLK) disable iff (RST)
		$fell(alarm) |-> $past(stopwatch))
		else
		begin
			failCount++;
			$error("alarm ended without stopwatch");
		end

	// Ends no later than AlarmCycles after the rise
	alarmEnds: assert property (@(posedge CLK) disable iff (RST)
		$rose(alarm) |-> ##AlarmCycles !alarm)
		else
		begin
			failCount++;
			$error("alarm longer than AlarmCycles");
		end

	// And not earlier
	alarmLong: assert property (@(posedge CLK) disable iff (RST)
		$fell(alarm) |-> $past(alarm, AlarmCycles) && !$past(alarm, AlarmCycles + 1))
		else
		begin
			failCount++;
			$error("alarm length differs from AlarmCycles");
		end

endmodule

bind rtcMenu rtcMenu_properties #(.AlarmCycles(AlarmCycles)) props_i (
	.CLK(CLK), .RST(RST), .busReq(busReq), .busAck(busAck),
	.alarm(alarm), .stopwatch(stopwatch)
);

//--- hw/rtcMenu.sv
`timescale 1ns/1ps

module rtcMenu import rtcMenuPkg::*; #(
	parameter int WaitCycles = 5,
	parameter int AlarmCycles = 3
) (
	input  logic CLK,
	input  logic RST,
	input  logic irq,
	input  logic btnUp,
	input  logic btnDown,
	input  logic btnLeft,
	input  logic btnRight,
	input  logic btnCenter,
	input  logic [7:0] busRdata,
	input  logic busAck,
	output logic busReq,
	output logic busWe,
	output rtcAddr_t busAddr,
	output logic [7:0] busWdata,
	output rtcAddr_t cursor,
	output logic [7:0] cursorValue,
	output logic writing,
	output logic alarm,
	output logic stopwatch
);

	rtcBusIf bus ();                   // Sequencer to pin master

	////////////////////
	// Register sweeps
	////////////////////
	sweepSequencer #(.WaitCycles(WaitCycles)) sequencer_i (
		.CLK(CLK), .RST(RST), .commit(btnCenter), .bus(bus.requester), .writing(writing)
	);

	rtcBusMaster master_i (
		.CLK(CLK), .RST(RST), .bus(bus.responder),
		.busReq(busReq), .busWe(busWe), .busAddr(busAddr), .busWdata(busWdata),
		.busRdata(busRdata), .busAck(busAck)
	);

	////////////////////
	// Editing
	////////////////////
	rtcShadowRegs shadow_i (
		.CLK(CLK), .RST(RST), .bus(bus.observer), .cursor(cursor),
		.up(btnUp), .down(btnDown), .cursorValue(cursorValue)
	);

	cursorControl cursor_i (
		.CLK(CLK), .RST(RST), .left(btnLeft), .right(btnRight), .center(btnCenter),
		.cursor(cursor)
	);

	// Interrupt to alarm pulse
	alarmTimer #(.AlarmCycles(AlarmCycles)) alarm_i (
		.CLK(CLK), .RST(RST), .irq(irq), .alarm(alarm), .stopwatch(stopwatch)
	);

endmodule

//--- hw/alarmTimer.sv
`timescale 1ns/1ps

module alarmTimer #(
	parameter int AlarmCycles = 3      // Alarm pulse length
) (
	input  logic CLK,
	input  logic RST,
	input  logic irq,
	output logic alarm,
	output logic stopwatch
);

	localparam int CntW = $clog2(AlarmCycles + 1);

	logic active;                      // 0 idle, 1 alarm running
	logic [CntW-1:0] cnt;

	assign alarm = active;
	assign stopwatch = active && (cnt == CntW'(AlarmCycles));  // Last alarm cycle

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			active <= 1'b0;
			cnt <= '0;
		end
		else if (!active)
		begin
			if (irq)
			begin
				active <= 1'b1;
				cnt <= CntW'(1);
			end
		end
		else if (stopwatch)
			active <= 1'b0;              // irq while running is dropped
		else
			cnt <= cnt + CntW'(1);
	end

endmodule

//--- hw/cursorControl.sv
`timescale 1ns/1ps

module cursorControl import rtcMenuPkg::*; (
	input  logic CLK,
	input  logic RST,
	input  logic left,
	input  logic right,
	input  logic center,
	output rtcAddr_t cursor
);

	rtcAddr_t cursorNext;

	// Step with jumps over the gap between blocks
	always_comb
	begin
		cursorNext = cursor;
		if (center)
			cursorNext = TimeFirst;      // Home, beats the arrows
		else if (left)
		begin
			if (cursor == TimeLast)
				cursorNext = TimerFirst;
			else if (cursor == TimerLast)
				cursorNext = TimeFirst;  // Wrap to start
			else
				cursorNext = cursor + 7'd1;
		end
		else if (right)
		begin
			if (cursor == TimeFirst)
				cursorNext = TimerLast;  // Wrap to end
			else if (cursor == TimerFirst)
				cursorNext = TimeLast;
			else
				cursorNext = cursor - 7'd1;
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			cursor <= TimeFirst;
		else
			cursor <= cursorNext;
	end

endmodule

//--- hw/rtcShadowRegs.sv
`timescale 1ns/1ps

module rtcShadowRegs import rtcMenuPkg::*; (
	input  logic CLK,
	input  logic RST,
	rtcBusIf.observer bus,
	input  rtcAddr_t cursor,
	input  logic up,
	input  logic down,
	output logic [7:0] cursorValue
);

	rtcByte_t shadow [RegCount];
	logic editing;                     // Local edits not yet written back
	logic [3:0] curIdx, busIdx;
	logic readDone, writeDone;

	// 99 wraps to 00
	function automatic rtcByte_t bcdInc(input rtcByte_t b);
		rtcByte_t r;
		r = b;
		if (b.bcd.units == 4'd9)
		begin
			r.bcd.units = 4'd0;
			r.bcd.tens = (b.bcd.tens == 4'd9) ? 4'd0 : b.bcd.tens + 4'd1;
		end
		else
			r.bcd.units = b.bcd.units + 4'd1;
		return r;
	endfunction

	// 00 wraps to 99
	function automatic rtcByte_t bcdDec(input rtcByte_t b);
		rtcByte_t r;
		r = b;
		if (b.bcd.units == 4'd0)
		begin
			r.bcd.units = 4'd9;
			r.bcd.tens = (b.bcd.tens == 4'd0) ? 4'd9 : b.bcd.tens - 4'd1;
		end
		else
			r.bcd.units = b.bcd.units - 4'd1;
		return r;
	endfunction

	assign curIdx = regIndex(cursor);
	assign busIdx = regIndex(bus.addr);
	assign readDone = bus.valid && bus.ready && !bus.write;
	assign writeDone = bus.valid && bus.ready && bus.write && (bus.addr == TimerLast);
	assign bus.wdata = shadow[busIdx].raw;
	assign cursorValue = shadow[curIdx].raw;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			for (int i = 0; i < RegCount; i++)
				shadow[i] <= '0;
			editing <= 1'b0;
		end
		else
		begin
			if (readDone && !editing)
				shadow[busIdx].raw <= bus.rdata;   // Refresh from chip
			// Button edit wins over a same-cycle read
			if (up)
				shadow[curIdx] <= bcdInc(shadow[curIdx]);
			else if (down)
				shadow[curIdx] <= bcdDec(shadow[curIdx]);
			if (up || down)
				editing <= 1'b1;
			else if (writeDone)
				editing <= 1'b0;             // Whole shadow now on chip
		end
	end

endmodule

//--- hw/rtcBusMaster.sv
`timescale 1ns/1ps

module rtcBusMaster import rtcMenuPkg::*; (
	input  logic CLK,
	input  logic RST,
	rtcBusIf.responder bus,
	output logic busReq,
	output logic busWe,
	output rtcAddr_t busAddr,
	output logic [7:0] busWdata,
	input  logic [7:0] busRdata,
	input  logic busAck
);

	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StRequest = 2'd1;  // req high, waiting for ack
	localparam logic [1:0] StRelease = 2'd2;  // req low, waiting for ack to drop
	localparam logic [1:0] StDone = 2'd3;

	logic [1:0] state;
	logic [7:0] rdataQ;

	assign bus.ready = (state == StDone);   // Single cycle, valid still high
	assign bus.rdata = rdataQ;

	////////////////////
	// Four-phase FSM
	////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state <= StIdle;
			busReq <= 1'b0;
		end
		else
		begin
			case (state)
				StIdle: if (bus.valid)
				begin
					state <= StRequest;
					busReq <= 1'b1;
				end
				StRequest: if (busAck)
				begin
					state <= StRelease;
					busReq <= 1'b0;
				end
				StRelease: if (!busAck) state <= StDone;
				default: state <= StIdle;
			endcase
		end
	end

	// Pin payload, latched at transfer start
	always_ff @(posedge CLK)
	begin
		if (state == StIdle && bus.valid)
		begin
			busAddr <= bus.addr;
			busWe <= bus.write;
			busWdata <= bus.wdata;
		end
		if (state == StRequest && busAck)
			rdataQ <= busRdata;          // Chip data valid with ack
	end

endmodule

//--- hw/sweepSequencer.sv
`timescale 1ns/1ps

module sweepSequencer import rtcMenuPkg::*; #(
	parameter int WaitCycles = 5       // Idle gap between sweeps, at least 2
) (
	input  logic CLK,
	input  logic RST,
	input  logic commit,               // Center button
	rtcBusIf.requester bus,
	output logic writing
);

	localparam int WaitW = $clog2(WaitCycles + 1);

	localparam logic [1:0] MainSweep = 2'd0, MainWait = 2'd1, MainChoose = 2'd2;
	localparam logic CntIdle = 1'b0, CntRun = 1'b1;

	logic [1:0] mainState;
	logic cntState;
	logic waitBusy;
	logic [WaitW-1:0] waitCnt;
	logic pendingWrite;                // Commit seen, not yet served
	rtcAddr_t addr;

	logic sweepDone, waitDone;

	assign bus.valid = (cntState == CntRun);
	assign bus.addr  = addr;
	assign bus.write = writing;

	// Last ready of the sweep
	assign sweepDone = (cntState == CntRun) && bus.ready && (addr == TimerLast);
	assign waitDone  = waitBusy && (waitCnt == WaitW'(WaitCycles - 1));

	////////////////////
	// Main machine
	////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			mainState <= MainSweep;      // First sweep starts out of reset
			writing <= 1'b0;
			pendingWrite <= 1'b0;
		end
		else
		begin
			case (mainState)
				MainSweep: if (sweepDone)
				begin
					mainState <= MainWait;
					writing <= 1'b0;
				end
				MainWait: if (waitDone) mainState <= MainChoose;
				default:
				begin
					// Pick direction of the next sweep
					mainState <= MainSweep;
					writing <= pendingWrite | commit;
				end
			endcase
			if (mainState == MainChoose)
				pendingWrite <= 1'b0;
			else if (commit)
				pendingWrite <= 1'b1;    // Held until the running sweep ends
		end
	end

	////////////////////
	// Count machine
	////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			cntState <= CntRun;
			addr <= TimeFirst;
		end
		else if (cntState == CntIdle)
		begin
			if (mainState == MainChoose) cntState <= CntRun;
		end
		else if (bus.ready)
		begin
			if (addr == TimerLast)
			begin
				cntState <= CntIdle;
				addr <= TimeFirst;       // Ready for next sweep
			end
			else if (addr == TimeLast)
				addr <= TimerFirst;      // Jump to timer block
			else
				addr <= addr + 7'd1;
		end
	end

	// Wait counter, Choose adds the last idle cycle
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			waitBusy <= 1'b0;
			waitCnt <= '0;
		end
		else if (sweepDone)
		begin
			waitBusy <= 1'b1;
			waitCnt <= WaitW'(1);
		end
		else if (waitDone)
			waitBusy <= 1'b0;
		else if (waitBusy)
			waitCnt <= waitCnt + WaitW'(1);
	end

endmodule

//--- hw/rtcBusIf.sv
`timescale 1ns/1ps

// One register transfer at a time, valid held until ready
interface rtcBusIf import rtcMenuPkg::*; ();

	logic     valid;   // Request pending
	logic     write;   // 1 = write sweep
	rtcAddr_t addr;
	logic     ready;   // One-cycle completion pulse
	logic [7:0] wdata; // From shadow entry at addr
	logic [7:0] rdata; // Valid with ready on a read

	modport requester (output valid, output write, output addr, input ready);

	modport responder (input valid, input write, input addr, input wdata,
		output ready, output rdata);

	// Shadow snoops completions and supplies write data
	modport observer (input valid, input write, input addr, input ready,
		input rdata, output wdata);

endinterface

//--- hw/rtcMenuPkg.sv
package rtcMenuPkg;

	////////////////////
	// Address map
	////////////////////

	typedef logic [6:0] rtcAddr_t;      // RTC register address

	localparam int RegCount = 11;       // 7 time + 4 timer registers

	localparam rtcAddr_t TimeFirst  = 7'h21;  // Seconds
	localparam rtcAddr_t TimeLast   = 7'h27;  // Year
	localparam rtcAddr_t TimerFirst = 7'h41;
	localparam rtcAddr_t TimerLast  = 7'h44;

	////////////////////
	// Register byte
	////////////////////

	// Same byte seen by the bus and by the BCD editor
	typedef union packed
	{
		logic [7:0] raw;
		struct packed
		{
			logic [3:0] tens;
			logic [3:0] units;
		} bcd;
	} rtcByte_t;

	// Window address to shadow slot, time block first
	function automatic logic [3:0] regIndex(input rtcAddr_t addr);
		logic [6:0] offset;
		if (addr >= TimerFirst)
			offset = addr - TimerFirst + (TimeLast - TimeFirst + 7'd1);  // Timer block after time
		else
			offset = addr - TimeFirst;
		return offset[3:0];
	endfunction

endpackage
